// File: hdl/icache_cfg.svh
// instruction cache geometry
// address width, number of lines and words per line for the
// direct-mapped fetch cache
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// fetch and bus address width in bits
`define ADDR_BITS 32

// number of lines in the direct-mapped array
`define ICACHE_LINES 16

// 32-bit words per line, a power of two
`define LINE_WORDS 4

`endif

// File: hdl/memPkg.sv
// memory side types
// bus word, cache line, and the index and tag fields of an address
`default_nettype none

package memPkg;
   `include "icache_cfg.svh"

   // address field widths derived from the geometry
   localparam int WORD_SEL_BITS = $clog2(`LINE_WORDS);
   localparam int OFFSET_BITS = WORD_SEL_BITS + 2;
   localparam int INDEX_BITS = $clog2(`ICACHE_LINES);
   localparam int TAG_BITS = `ADDR_BITS - INDEX_BITS - OFFSET_BITS;

   typedef logic [31:0] word_t;

   // one full line, word 0 in the low bits
   typedef word_t [`LINE_WORDS-1:0] line_t;

   typedef logic [INDEX_BITS-1:0] index_t;
   typedef logic [TAG_BITS-1:0] tag_t;

   // word select inside a line
   typedef logic [WORD_SEL_BITS-1:0] wordSel_t;
endpackage

`default_nettype wire

// File: hdl/fetchPkg.sv
// fetch side types
// fetch address, the instruction word seen whole or by halves,
// and the lookup address select code
`default_nettype none

package fetchPkg;
   `include "icache_cfg.svh"

   typedef logic [`ADDR_BITS-1:0] addr_t;

   // one 16-bit parcel of an instruction
   typedef logic [15:0] half_t;

   // merge logic fills the halves, the cpu side reads it whole
   typedef union packed {
      logic [31:0] whole;
      struct packed {
         half_t hi;
         half_t lo;
      } half;
   } instrWord_t;

   // lookup address choice
   typedef enum logic [1:0] {
      SEL_PC,     // current fetch address from the cpu
      SEL_HELD,   // address of the access in progress
      SEL_NEXT    // start of the following line, for spills
   } selAdr_t;
endpackage

`default_nettype wire

// File: hdl/icacheIf.sv
// cache internal interfaces
// fillIf carries a finished line from the fill unit into the array,
// lookupIf carries a read request and its registered result
`timescale 1ns/1ps
`default_nettype none

interface fillIf;
   memPkg::line_t line;
   memPkg::index_t index;
   memPkg::tag_t tag;
   logic memWriteEn;

   // fill unit assembles the line and its location
   modport producer (
      output line, index, tag
   );

   // controller decides when the line is written
   modport controller (
      output memWriteEn
   );

   modport array (
      input line, index, tag, memWriteEn
   );
endinterface

interface lookupIf;
   logic readEn;
   fetchPkg::addr_t adr;
   // addressed word in [0], following word of the line in [1]
   memPkg::word_t [1:0] wordPair;
   logic hit;

   modport align (
      output readEn, adr,
      input wordPair, hit
   );

   modport array (
      input readEn, adr,
      output wordPair, hit
   );
endinterface

`default_nettype wire

// File: hdl/icacheFsm.sv
// instruction cache controller
// sequences lookup, line fill and spill merge, and holds the
// returned instruction while the cpu is stalled
`timescale 1ns/1ps
`default_nettype none

module icacheFsm (
   input  logic clk,
   input  logic reset,
   input  logic stallF,
   input  logic hit,
   input  logic spill,
   input  logic fetchCountFlag,
   input  logic busAck,
   fillIf.controller fill,
   output logic icacheStallF,
   output logic busRead,
   output logic readEn,
   output logic spillSave,
   output logic cntReset,
   output fetchPkg::selAdr_t selAdr
);
   import fetchPkg::*;

   typedef enum logic [4:0] {
      STATE_READY,                      // issue lookup of pcF
      STATE_CHECK,                      // registered result for held address
      STATE_HIT_SPILL,                  // first half hit, next line looked up
      STATE_HIT_SPILL_MISS_FETCH_WDV,
      STATE_HIT_SPILL_MISS_FETCH_DONE,
      STATE_HIT_SPILL_MERGE,
      STATE_HIT_SPILL_FINAL,
      STATE_MISS_FETCH_WDV,
      STATE_MISS_FETCH_DONE,
      STATE_MISS_READ,
      STATE_MISS_READ_DELAY,
      STATE_MISS_SPILL_FETCH_WDV,
      STATE_MISS_SPILL_FETCH_DONE,
      STATE_MISS_SPILL_READ1,
      STATE_MISS_SPILL_2,
      STATE_MISS_SPILL_2_START,
      STATE_MISS_SPILL_MISS_FETCH_WDV,
      STATE_MISS_SPILL_MISS_FETCH_DONE,
      STATE_MISS_SPILL_MERGE,
      STATE_MISS_SPILL_FINAL,
      STATE_CPU_BUSY
   } state_t;

   state_t currState, nextState;
   logic memWriteEn;
   logic fillDone;

   // last word of the line acknowledged
   assign fillDone = fetchCountFlag & busAck;

   always_ff @(posedge clk or posedge reset) begin
      if (reset)
         currState <= STATE_READY;
      else
         currState <= nextState;
   end

   ////////////////////////////////////////
   // next state and outputs
   ////////////////////////////////////////
   always_comb begin
      nextState = currState;
      cntReset = 1'b0;
      memWriteEn = 1'b0;
      spillSave = 1'b0;
      selAdr = SEL_HELD;
      readEn = 1'b0;
      icacheStallF = 1'b1;
      case (currState)
         STATE_READY: begin
            selAdr = SEL_PC;
            readEn = 1'b1;
            nextState = STATE_CHECK;
         end
         STATE_CHECK: begin
            if (hit & ~spill) begin
               icacheStallF = 1'b0;
               nextState = stallF ? STATE_CPU_BUSY : STATE_READY;
            end else if (hit & spill) begin
               // keep the upper half, then look at the next line
               spillSave = 1'b1;
               selAdr = SEL_NEXT;
               readEn = 1'b1;
               nextState = STATE_HIT_SPILL;
            end else begin
               cntReset = 1'b1;
               nextState = spill ? STATE_MISS_SPILL_FETCH_WDV : STATE_MISS_FETCH_WDV;
            end
         end
         // branch 1 and 2, first line hit
         STATE_HIT_SPILL: begin
            selAdr = SEL_NEXT;
            if (hit) begin
               nextState = STATE_HIT_SPILL_FINAL;
            end else begin
               cntReset = 1'b1;
               nextState = STATE_HIT_SPILL_MISS_FETCH_WDV;
            end
         end
         STATE_HIT_SPILL_MISS_FETCH_WDV: begin
            selAdr = SEL_NEXT;
            if (fillDone)
               nextState = STATE_HIT_SPILL_MISS_FETCH_DONE;
         end
         STATE_HIT_SPILL_MISS_FETCH_DONE: begin
            selAdr = SEL_NEXT;
            memWriteEn = 1'b1;
            nextState = STATE_HIT_SPILL_MERGE;
         end
         STATE_HIT_SPILL_MERGE: begin
            selAdr = SEL_NEXT;
            readEn = 1'b1;
            nextState = STATE_HIT_SPILL_FINAL;
         end
         // merged spill instruction goes out, spill is ignored here
         STATE_HIT_SPILL_FINAL: begin
            icacheStallF = 1'b0;
            nextState = stallF ? STATE_CPU_BUSY : STATE_READY;
         end
         // branch 3, aligned or in-line miss
         STATE_MISS_FETCH_WDV: begin
            if (fillDone)
               nextState = STATE_MISS_FETCH_DONE;
         end
         STATE_MISS_FETCH_DONE: begin
            memWriteEn = 1'b1;
            nextState = STATE_MISS_READ;
         end
         STATE_MISS_READ: begin
            readEn = 1'b1;
            nextState = STATE_MISS_READ_DELAY;
         end
         STATE_MISS_READ_DELAY: begin
            readEn = 1'b1;
            icacheStallF = 1'b0;
            nextState = stallF ? STATE_CPU_BUSY : STATE_READY;
         end
         // branch 4 and 5, first line missed
         STATE_MISS_SPILL_FETCH_WDV: begin
            if (fillDone)
               nextState = STATE_MISS_SPILL_FETCH_DONE;
         end
         STATE_MISS_SPILL_FETCH_DONE: begin
            memWriteEn = 1'b1;
            nextState = STATE_MISS_SPILL_READ1;
         end
         // always a hit, line was just written
         STATE_MISS_SPILL_READ1: begin
            readEn = 1'b1;
            nextState = STATE_MISS_SPILL_2;
         end
         STATE_MISS_SPILL_2: begin
            spillSave = 1'b1;
            selAdr = SEL_NEXT;
            readEn = 1'b1;
            nextState = STATE_MISS_SPILL_2_START;
         end
         STATE_MISS_SPILL_2_START: begin
            selAdr = SEL_NEXT;
            if (~hit) begin
               cntReset = 1'b1;
               nextState = STATE_MISS_SPILL_MISS_FETCH_WDV;
            end else begin
               icacheStallF = 1'b0;
               nextState = stallF ? STATE_CPU_BUSY : STATE_READY;
            end
         end
         STATE_MISS_SPILL_MISS_FETCH_WDV: begin
            selAdr = SEL_NEXT;
            if (fillDone)
               nextState = STATE_MISS_SPILL_MISS_FETCH_DONE;
         end
         STATE_MISS_SPILL_MISS_FETCH_DONE: begin
            selAdr = SEL_NEXT;
            memWriteEn = 1'b1;
            nextState = STATE_MISS_SPILL_MERGE;
         end
         STATE_MISS_SPILL_MERGE: begin
            selAdr = SEL_NEXT;
            readEn = 1'b1;
            nextState = STATE_MISS_SPILL_FINAL;
         end
         STATE_MISS_SPILL_FINAL: begin
            icacheStallF = 1'b0;
            nextState = stallF ? STATE_CPU_BUSY : STATE_READY;
         end
         // no read here, so the registered instruction stays put
         STATE_CPU_BUSY: begin
            icacheStallF = 1'b0;
            nextState = stallF ? STATE_CPU_BUSY : STATE_READY;
         end
         default: begin
            nextState = STATE_READY;
         end
      endcase
   end

   assign fill.memWriteEn = memWriteEn;

   // bus read held for the whole of every fill
   assign busRead = (currState == STATE_HIT_SPILL_MISS_FETCH_WDV) ||
                    (currState == STATE_MISS_FETCH_WDV) ||
                    (currState == STATE_MISS_SPILL_FETCH_WDV) ||
                    (currState == STATE_MISS_SPILL_MISS_FETCH_WDV);

   // line write only after the bus has let go
   assert property (@(posedge clk) disable iff (reset) !(busRead && fill.memWriteEn))
      else $error("busRead and memWriteEn high together");

   // cpu must see a stall across any fill
   assert property (@(posedge clk) disable iff (reset) busRead |-> icacheStallF)
      else $error("icacheStallF low during a line fill");
endmodule

`default_nettype wire

// File: hdl/lineFill.sv
// line fill unit
// counts acknowledged bus words, drives the bus word address and
// gathers the words into one line for the array
`timescale 1ns/1ps
`default_nettype none

`include "icache_cfg.svh"

module lineFill (
   input  logic clk,
   input  logic reset,
   input  logic cntReset,
   input  logic busRead,
   input  logic busAck,
   input  memPkg::word_t busRdata,
   input  fetchPkg::addr_t fillAdr,
   output fetchPkg::addr_t busAdr,
   output logic fetchCountFlag,
   fillIf.producer fill
);
   import memPkg::*;

   localparam int BASE_BITS = `ADDR_BITS - OFFSET_BITS;

   logic [BASE_BITS-1:0] lineBase;
   wordSel_t count;
   line_t lineBuf;
   logic wordTaken;

   assign wordTaken = busRead & busAck;

   // line base and word counter
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         lineBase <= '0;
         count <= '0;
      end else if (cntReset) begin
         lineBase <= fillAdr[`ADDR_BITS-1:OFFSET_BITS];
         count <= '0;
      end else if (wordTaken) begin
         count <= count + 1'b1;
      end
   end

   // assembly buffer, one word per acknowledge
   always_ff @(posedge clk) begin
      if (wordTaken)
         lineBuf[count] <= busRdata;
   end

   // word address, not byte address
   assign busAdr = {2'b00, lineBase, count};
   assign fetchCountFlag = (count == WORD_SEL_BITS'(`LINE_WORDS - 1));

   assign fill.line = lineBuf;
   assign fill.index = lineBase[INDEX_BITS-1:0];
   assign fill.tag = lineBase[BASE_BITS-1:INDEX_BITS];

   assert property (@(posedge clk) disable iff (reset) busAck |-> busRead)
      else $error("busAck without busRead");
endmodule

`default_nettype wire

// File: hdl/icacheArray.sv
// instruction cache array
// valid bits, tags and line data for a direct-mapped cache,
// with a registered word pair read and a registered hit flag
`timescale 1ns/1ps
`default_nettype none

`include "icache_cfg.svh"

module icacheArray (
   input  logic clk,
   input  logic reset,
   fillIf.array fill,
   lookupIf.array lookup
);
   import memPkg::*;

   logic [`ICACHE_LINES-1:0] valid;
   tag_t tagMem [`ICACHE_LINES];
   line_t dataMem [`ICACHE_LINES];

   index_t rdIndex;
   tag_t rdTag;
   wordSel_t rdSel;
   wordSel_t rdSelNext;

   // split the lookup address into its fields
   assign rdSel = lookup.adr[OFFSET_BITS-1:2];
   assign rdIndex = lookup.adr[OFFSET_BITS+INDEX_BITS-1:OFFSET_BITS];
   assign rdTag = lookup.adr[`ADDR_BITS-1:OFFSET_BITS+INDEX_BITS];
   // wraps inside the line, the spill path covers the last word
   assign rdSelNext = rdSel + 1'b1;

   ////////////////////////////////////////
   // write side
   ////////////////////////////////////////
   always_ff @(posedge clk or posedge reset) begin
      if (reset)
         valid <= '0;
      else if (fill.memWriteEn)
         valid[fill.index] <= 1'b1;
   end

   always_ff @(posedge clk) begin
      if (fill.memWriteEn) begin
         tagMem[fill.index] <= fill.tag;
         dataMem[fill.index] <= fill.line;
      end
   end

   ////////////////////////////////////////
   // read side
   ////////////////////////////////////////
   always_ff @(posedge clk or posedge reset) begin
      if (reset)
         lookup.hit <= 1'b0;
      else if (lookup.readEn)
         lookup.hit <= valid[rdIndex] && (tagMem[rdIndex] == rdTag);
   end

   // data is read regardless of hit, the fsm qualifies it
   always_ff @(posedge clk) begin
      if (lookup.readEn) begin
         lookup.wordPair[0] <= dataMem[rdIndex][rdSel];
         lookup.wordPair[1] <= dataMem[rdIndex][rdSelNext];
      end
   end

   assert property (@(posedge clk) disable iff (reset)
      lookup.readEn |-> !$isunknown(lookup.adr))
      else $error("lookup address unknown on read");
endmodule

`default_nettype wire

// File: hdl/instrAlign.sv
// instruction alignment unit
// picks the lookup address, detects line spills, keeps the first
// half of a spilled instruction and builds the 32-bit instruction
`timescale 1ns/1ps
`default_nettype none

`include "icache_cfg.svh"

module instrAlign (
   input  logic clk,
   input  logic reset,
   input  fetchPkg::addr_t pcF,
   input  fetchPkg::selAdr_t selAdr,
   input  logic spillSave,
   lookupIf.align lookup,
   output logic spill,
   output fetchPkg::addr_t fillAdr,
   output fetchPkg::instrWord_t instrF
);
   import memPkg::*;
   import fetchPkg::*;

   localparam addr_t LINE_BYTES = addr_t'(`LINE_WORDS * 4);

   addr_t heldAdr;
   addr_t nextLineAdr;
   addr_t selectedAdr;
   half_t savedHi;

   // held address follows pcF whenever a new lookup starts
   always_ff @(posedge clk or posedge reset) begin
      if (reset)
         heldAdr <= '0;
      else if (selAdr == SEL_PC)
         heldAdr <= pcF;
   end

   assign nextLineAdr = (heldAdr & ~(LINE_BYTES - 1'b1)) + LINE_BYTES;

   always_comb begin
      case (selAdr)
         SEL_PC: selectedAdr = pcF;
         SEL_NEXT: selectedAdr = nextLineAdr;
         default: selectedAdr = heldAdr;
      endcase
   end

   assign lookup.adr = selectedAdr;
   assign fillAdr = selectedAdr;

   // last halfword of a line
   assign spill = &heldAdr[OFFSET_BITS-1:1];

   // upper half of the first line's last word
   always_ff @(posedge clk) begin
      if (spillSave)
         savedHi <= lookup.wordPair[0][31:16];
   end

   ////////////////////////////////////////
   // instruction merge
   ////////////////////////////////////////
   always_comb begin
      if (spill) begin
         // pair now holds word 0 of the next line
         instrF.half.lo = savedHi;
         instrF.half.hi = lookup.wordPair[0][15:0];
      end else if (heldAdr[1]) begin
         instrF.half.lo = lookup.wordPair[0][31:16];
         instrF.half.hi = lookup.wordPair[1][15:0];
      end else begin
         instrF.half.lo = lookup.wordPair[0][15:0];
         instrF.half.hi = lookup.wordPair[0][31:16];
      end
   end
endmodule

`default_nettype wire

// File: hdl/icacheTop.sv
// instruction cache top level
// direct-mapped fetch cache with line fill over a simple word bus
`timescale 1ns/1ps
`default_nettype none

`include "icache_cfg.svh"

module icacheTop (
   input  logic clk,
   input  logic reset,
   input  logic [`ADDR_BITS-1:0] pcF,
   input  logic stallF,
   output logic [31:0] instrF,
   output logic icacheStallF,
   output logic busRead,
   output logic [`ADDR_BITS-1:0] busAdr,
   input  logic [31:0] busRdata,
   input  logic busAck
);
   import fetchPkg::*;

   fillIf fill ();
   lookupIf lookup ();

   logic spill;
   logic spillSave;
   logic cntReset;
   logic fetchCountFlag;
   logic readEn;
   selAdr_t selAdr;
   addr_t fillAdr;
   instrWord_t instrWord;

   // fsm read enable drives lookupIf directly
   assign lookup.readEn = readEn;

   // merged halves leave the cache as one word
   assign instrF = instrWord.whole;

   icacheFsm u_icacheFsm (
      .clk(clk),
      .reset(reset),
      .stallF(stallF),
      .hit(lookup.hit),
      .spill(spill),
      .fetchCountFlag(fetchCountFlag),
      .busAck(busAck),
      .fill(fill.controller),
      .icacheStallF(icacheStallF),
      .busRead(busRead),
      .readEn(readEn),
      .spillSave(spillSave),
      .cntReset(cntReset),
      .selAdr(selAdr)
   );

   lineFill u_lineFill (
      .clk(clk),
      .reset(reset),
      .cntReset(cntReset),
      .busRead(busRead),
      .busAck(busAck),
      .busRdata(busRdata),
      .fillAdr(fillAdr),
      .busAdr(busAdr),
      .fetchCountFlag(fetchCountFlag),
      .fill(fill.producer)
   );

   icacheArray u_icacheArray (
      .clk(clk),
      .reset(reset),
      .fill(fill.array),
      .lookup(lookup.array)
   );

   instrAlign u_instrAlign (
      .clk(clk),
      .reset(reset),
      .pcF(pcF),
      .selAdr(selAdr),
      .spillSave(spillSave),
      .lookup(lookup.align),
      .spill(spill),
      .fillAdr(fillAdr),
      .instrF(instrWord)
   );
endmodule

`default_nettype wire

// File: test/clockGen.sv
// testbench clock and reset
// 20 ns clock, reset held high across the first 16 rising edges
`timescale 1ns/1ps
`default_nettype none

module clockGen (
   output logic clk,
   output logic reset
);
   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   initial begin
      reset = 1'b1;
      repeat (16) @(posedge clk);
      // release on a falling edge, away from the active edge
      @(negedge clk);
      reset = 1'b0;
   end
endmodule

`default_nettype wire

// File: test/icacheTb.sv
// instruction cache testbench
// runs fetches through the cache against a word bus memory model,
// checks every returned instruction against a reference model and
// checks the bus word order of every line fill
`timescale 1ns/1ps
`default_nettype none

`include "icache_cfg.svh"

module icacheTb;
   localparam int LINE_BYTES = `LINE_WORDS * 4;
   localparam int FETCH_TIMEOUT = 200;
   localparam int RESET_TIMEOUT = 50;

   logic clk;
   logic reset;
   logic [31:0] pcF;
   logic stallF;
   logic [31:0] instrF;
   logic icacheStallF;
   logic busRead;
   logic [31:0] busAdr;
   logic [31:0] busRdata = '0;
   logic busAck = 1'b0;

   // fetch in progress and run bookkeeping
   logic [31:0] expAdr;
   integer seed = 32'hf55009cc;
   int errCount = 0;
   int checkCount = 0;
   bit timedOut = 1'b0;

   // lines the cache should hold, and fills still owed on the bus
   logic [31:0] modelLine [`ICACHE_LINES];
   bit modelValid [`ICACHE_LINES];
   logic [31:0] fillQ [$];

   // bus model state
   logic [31:0] fillLine;
   int wordIdx = 0;
   int delayLeft = 0;

   clockGen u_clockGen (
      .clk(clk),
      .reset(reset)
   );

   icacheTop u_icacheTop (
      .clk(clk),
      .reset(reset),
      .pcF(pcF),
      .stallF(stallF),
      .instrF(instrF),
      .icacheStallF(icacheStallF),
      .busRead(busRead),
      .busAdr(busAdr),
      .busRdata(busRdata),
      .busAck(busAck)
   );

   ////////////////////////////////////////
   // reference model
   ////////////////////////////////////////
   // memory contents, mixed from the whole word address
   function automatic logic [31:0] memWord(input logic [31:0] w);
      logic [31:0] x;
      x = (w ^ 32'h2545f491) * 32'h9e3779b1;
      x = x ^ (x >> 15);
      return x;
   endfunction

   // expected instruction at a halfword address
   function automatic logic [31:0] refInstr(input logic [31:0] adr);
      logic [31:0] first;
      logic [31:0] second;
      first = memWord(adr >> 2);
      second = memWord((adr >> 2) + 32'd1);
      if (adr[1])
         return {second[15:0], first[31:16]};
      return first;
   endfunction

   task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
      checkCount++;
      if (actual !== expected) begin
         errCount++;
         $display("FAIL at %0d ns: %s is %h, expected %h", $time, what, actual, expected);
      end
   endtask

   // a line not held by the direct-mapped model must come over the bus
   task automatic expectLine(input logic [31:0] lineNum);
      int idx;
      idx = int'(lineNum % `ICACHE_LINES);
      if (!modelValid[idx] || modelLine[idx] != lineNum) begin
         fillQ.push_back(lineNum);
         modelValid[idx] = 1'b1;
         modelLine[idx] = lineNum;
      end
   endtask

   ////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////
   // one fetch, entered on the falling edge of a ready cycle
   task automatic fetchAt(input logic [31:0] adr, input int hold);
      int waitCycles;
      logic [31:0] lineNum;
      if (timedOut)
         return;
      lineNum = adr / LINE_BYTES;
      pcF = adr;
      expAdr = adr;
      stallF = (hold > 0);
      expectLine(lineNum);
      // last halfword of a line also needs the next line
      if ((adr % LINE_BYTES) == LINE_BYTES - 2)
         expectLine(lineNum + 32'd1);
      waitCycles = 0;
      @(negedge clk);
      while (icacheStallF && waitCycles < FETCH_TIMEOUT) begin
         @(negedge clk);
         waitCycles++;
      end
      if (icacheStallF) begin
         timedOut = 1'b1;
         errCount++;
         $display("timeout, no instruction returned for address %h within %0d cycles",
                  adr, FETCH_TIMEOUT);
         return;
      end
      checkValue(32'(fillQ.size()), 32'd0, "line fills still owed");
      // cpu holds the instruction, cache must stay quiet
      for (int i = 0; i < hold; i++) begin
         @(negedge clk);
         checkValue(32'(icacheStallF), 32'd0, "icacheStallF during cpu stall");
         checkValue(32'(busRead), 32'd0, "busRead during cpu stall");
      end
      stallF = 1'b0;
      @(negedge clk);
   endtask

   // word bus memory, 0 to 3 idle cycles before each acknowledge
   always @(negedge clk) begin
      busAck = 1'b0;
      if (busRead) begin
         if (delayLeft == 0) begin
            if (wordIdx == 0) begin
               if (fillQ.size() == 0) begin
                  errCount++;
                  $display("unexpected line fill at bus word address %h", busAdr);
                  fillLine = busAdr / `LINE_WORDS;
               end else begin
                  fillLine = fillQ.pop_front();
               end
            end
            checkValue(busAdr, fillLine * `LINE_WORDS + wordIdx, "busAdr");
            busRdata = memWord(busAdr);
            busAck = 1'b1;
            wordIdx = (wordIdx + 1) % `LINE_WORDS;
            delayLeft = $unsigned($random(seed)) % 4;
         end else begin
            delayLeft--;
         end
      end
   end

   // every returned instruction against the reference
   always @(negedge clk) begin
      if (icacheStallF === 1'b0)
         checkValue(instrF, refInstr(expAdr), "instrF");
   end

   initial begin
      logic [31:0] r;
      int hold;
      int waitCycles;
      pcF = '0;
      stallF = 1'b0;
      expAdr = '0;
      // first fetch only once reset has been released
      waitCycles = 0;
      while (reset !== 1'b0 && waitCycles < RESET_TIMEOUT) begin
         @(posedge clk);
         waitCycles++;
      end
      if (reset !== 1'b0) begin
         timedOut = 1'b1;
         errCount++;
         $display("timeout, reset still asserted after %0d cycles", RESET_TIMEOUT);
      end
      @(negedge clk);
      // cold misses, aligned
      fetchAt(32'h0000_1000, 0);
      fetchAt(32'h0000_1010, 0);
      fetchAt(32'h0000_1024, 0);
      // repeated and sequential hits
      fetchAt(32'h0000_1004, 0);
      fetchAt(32'h0000_1008, 0);
      fetchAt(32'h0000_100c, 0);
      fetchAt(32'h0000_1000, 0);
      fetchAt(32'h0000_1000, 0);
      fetchAt(32'h0000_1028, 0);
      // unaligned but inside one line
      fetchAt(32'h0000_1002, 0);
      fetchAt(32'h0000_1006, 0);
      fetchAt(32'h0000_100a, 0);
      fetchAt(32'h0000_1026, 0);
      fetchAt(32'h0000_10a6, 0);
      // spills, hit-hit then hit-miss
      fetchAt(32'h0000_100e, 0);
      fetchAt(32'h0000_102e, 0);
      // miss-hit, second line loaded first
      fetchAt(32'h0000_1070, 0);
      fetchAt(32'h0000_106e, 0);
      // miss-miss, and one that wraps to index 0
      fetchAt(32'h0000_108e, 0);
      fetchAt(32'h0000_10fe, 0);
      // cpu stall on a hit, a miss and two spills
      fetchAt(32'h0000_1028, 3);
      fetchAt(32'h0000_10b0, 4);
      fetchAt(32'h0000_102e, 2);
      fetchAt(32'h0000_10ce, 2);
      // same index, lines evict each other
      fetchAt(32'h0000_1100, 0);
      fetchAt(32'h0000_1000, 0);
      fetchAt(32'h0000_1104, 0);
      fetchAt(32'h0000_1000, 0);
      // random halfword addresses over 64 lines
      for (int i = 0; i < 80; i++) begin
         r = $random(seed);
         hold = $unsigned($random(seed)) % 3;
         fetchAt(32'h0000_2000 | (r & 32'h0000_03fe), hold);
      end
      $display("checks: %0d, errors: %0d", checkCount, errCount);
      if (errCount == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end
endmodule

`default_nettype wire

// File: vlog.f
+incdir+hdl
hdl/memPkg.sv
hdl/fetchPkg.sv
hdl/icacheIf.sv
hdl/icacheFsm.sv
hdl/lineFill.sv
hdl/icacheArray.sv
hdl/instrAlign.sv
hdl/icacheTop.sv
test/clockGen.sv
test/icacheTb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = icacheTb
FILELIST = vlog.f
OBJDIR   = obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --Mdir $(OBJDIR) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJDIR)
